/* design/system1_pkg.sv */
`default_nettype none

package system1_pkg;

	typedef logic [24:0] dl_addr_t;     // ioctl byte address
	typedef logic [22:0] word_addr_t;   // sdram 16-bit word address
	typedef logic [1:0]  lane_t;        // [1] selects the high byte
	typedef logic [6:0]  game_id_t;

	typedef struct packed {
		dl_addr_t   addr;
		logic [7:0] data;
	} dl_byte_t;

	typedef struct packed {
		logic       port;   // 0 main/sound, 1 tiles
		word_addr_t addr;
		lane_t      lane;
		logic [15:0] data;
	} mem_cmd_t;

	typedef struct packed {
		logic right;
		logic left;
		logic down;
		logic up;
		logic fire_a;
		logic fire_b;
	} player_ctl_t;

	typedef struct packed {
		logic coin;
		logic start1;
		logic start2;
	} sys_ctl_t;

	// rom set layout
	localparam dl_addr_t TILE_BASE = 25'h0022000;
	localparam dl_addr_t ROM_END   = 25'h002E180;

	localparam int QUEUE_DEPTH = 4;
	localparam int QUEUE_PTR_W = $clog2(QUEUE_DEPTH);
	localparam int CREDIT_W    = $clog2(QUEUE_DEPTH + 1);

	localparam game_id_t GAME_FLICKY     = 7'd0;
	localparam game_id_t GAME_PITFALL2   = 7'd1;
	localparam game_id_t GAME_STARJACKER = 7'd2;
	localparam game_id_t GAME_REGULUS    = 7'd3;
	localparam game_id_t GAME_UPNDOWN    = 7'd4;
	localparam game_id_t GAME_MYHERO     = 7'd5;
	localparam game_id_t GAME_NINJA      = 7'd6;
	localparam game_id_t GAME_MRVIKING   = 7'd7;

endpackage

`default_nettype wire

/* design/dl_receiver.sv */
`timescale 1ns/100ps
`default_nettype none

module dl_receiver
	import system1_pkg::*;
(
	input  wire            clk_sys,
	input  wire            rst_n,
	input  wire            ioctl_download,
	input  wire            ioctl_wr,
	input  wire dl_addr_t  ioctl_addr,
	input  wire [7:0]      ioctl_dout,
	input  wire            status_reset,
	input  wire            button_reset,
	output dl_byte_t       dl_byte,
	output logic           dl_valid,
	output logic           rom_loaded,
	output logic           core_reset
);

	logic wr_q;   // strobe, previous sample
	logic dl_q;   // download flag, previous sample

	always_ff @(posedge clk_sys or negedge rst_n)
	begin
		if (!rst_n)
		begin
			wr_q       <= 1'b0;
			dl_q       <= 1'b0;
			dl_valid   <= 1'b0;
			rom_loaded <= 1'b0;
			core_reset <= 1'b1;
		end
		else
		begin
			wr_q     <= ioctl_wr;
			dl_q     <= ioctl_download;
			dl_valid <= ioctl_download && ioctl_wr && !wr_q;
			// end of download latches loaded
			if (dl_q && !ioctl_download)
				rom_loaded <= 1'b1;
			core_reset <= status_reset || button_reset || !rom_loaded;
		end
	end

	always_ff @(posedge clk_sys)
	begin
		if (ioctl_wr && !wr_q)
		begin
			dl_byte.addr <= ioctl_addr;
			dl_byte.data <= ioctl_dout;
		end
	end

	// one byte per strobe, strobes never back to back
	a_valid_pulse: assert property (@(posedge clk_sys) disable iff (!rst_n)
		dl_valid |=> !dl_valid);

endmodule

`default_nettype wire

/* design/dl_addr_mapper.sv */
`timescale 1ns/100ps
`default_nettype none

module dl_addr_mapper
	import system1_pkg::*;
(
	input  wire            clk_sys,
	input  wire            rst_n,
	input  wire dl_byte_t  dl_byte,
	input  wire            dl_valid,
	input  wire            credit_return,
	output mem_cmd_t       cmd,
	output logic           cmd_valid,
	output logic           dl_overflow
);

	dl_addr_t tile_off;
	logic in_range;
	logic is_tile;
	logic has_credit;
	logic send;
	mem_cmd_t cmd_next;
	logic [CREDIT_W-1:0] credits;

	assign in_range   = dl_byte.addr < ROM_END;
	assign is_tile    = dl_byte.addr >= TILE_BASE;
	assign tile_off   = dl_byte.addr - TILE_BASE;
	assign has_credit = credits != '0;
	assign send       = dl_valid && in_range && has_credit;

	always_comb
	begin
		cmd_next.data = {dl_byte.data, dl_byte.data};
		if (is_tile)
		begin
			cmd_next.port = 1'b1;
			// tile roms side by side in wide words
			cmd_next.addr = {6'd0, tile_off[17:16], tile_off[13:0], tile_off[15]};
			cmd_next.lane = {tile_off[14], ~tile_off[14]};
		end
		else
		begin
			cmd_next.port = 1'b0;
			cmd_next.addr = dl_byte.addr[23:1];
			cmd_next.lane = {dl_byte.addr[0], ~dl_byte.addr[0]};
		end
	end

	always_ff @(posedge clk_sys or negedge rst_n)
	begin
		if (!rst_n)
		begin
			credits     <= CREDIT_W'(QUEUE_DEPTH);
			cmd_valid   <= 1'b0;
			dl_overflow <= 1'b0;
		end
		else
		begin
			cmd_valid <= send;
			credits   <= credits + CREDIT_W'(credit_return) - CREDIT_W'(send);
			if (dl_valid && in_range && !has_credit)
				dl_overflow <= 1'b1; // sticky
		end
	end

	always_ff @(posedge clk_sys)
	begin
		if (send)
			cmd <= cmd_next;
	end

	a_credit_max: assert property (@(posedge clk_sys) disable iff (!rst_n)
		credits <= CREDIT_W'(QUEUE_DEPTH));

	a_send_credit: assert property (@(posedge clk_sys) disable iff (!rst_n)
		$rose(cmd_valid) |-> $past(credits) != '0);

endmodule

`default_nettype wire

/* design/rom_write_queue.sv */
`timescale 1ns/100ps
`default_nettype none

module rom_write_queue
	import system1_pkg::*;
(
	input  wire            clk_sys,
	input  wire            rst_n,
	input  wire mem_cmd_t  cmd,
	input  wire            cmd_valid,
	input  wire            mem_ack,
	output logic           credit_return,
	output mem_cmd_t       mem_cmd,
	output logic           mem_req
);

	typedef enum logic {
		Q_IDLE,
		Q_WAIT
	} q_state_t;

	q_state_t state;
	mem_cmd_t fifo_mem [QUEUE_DEPTH];
	logic [QUEUE_PTR_W-1:0] wr_ptr;
	logic [QUEUE_PTR_W-1:0] rd_ptr;
	logic [CREDIT_W-1:0] count;
	logic issue;
	logic pop;

	assign issue = (state == Q_IDLE) && (count != '0);
	assign pop   = (state == Q_WAIT) && (mem_req == mem_ack);

	always_ff @(posedge clk_sys)
	begin
		if (cmd_valid)
			fifo_mem[wr_ptr] <= cmd;
		if (issue)
			mem_cmd <= fifo_mem[rd_ptr]; // head stays until acked
	end

	always_ff @(posedge clk_sys or negedge rst_n)
	begin
		if (!rst_n)
		begin
			state         <= Q_IDLE;
			wr_ptr        <= '0;
			rd_ptr        <= '0;
			count         <= '0;
			mem_req       <= 1'b0;
			credit_return <= 1'b0;
		end
		else
		begin
			credit_return <= pop;
			if (cmd_valid)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
			count <= count + CREDIT_W'(cmd_valid) - CREDIT_W'(pop);

			case (state)
				Q_IDLE:
				begin
					if (issue)
					begin
						mem_req <= ~mem_req;
						state   <= Q_WAIT;
					end
				end
				Q_WAIT:
				begin
					if (pop)
						state <= Q_IDLE;
				end
				default: state <= Q_IDLE;
			endcase
		end
	end

	// mapper credits must keep the fifo from overflowing
	a_no_push_full: assert property (@(posedge clk_sys) disable iff (!rst_n)
		cmd_valid |-> count != CREDIT_W'(QUEUE_DEPTH));

	a_cmd_stable: assert property (@(posedge clk_sys) disable iff (!rst_n)
		(mem_req != mem_ack) |=> $stable(mem_cmd));

endmodule

`default_nettype wire

/* design/game_input_mapper.sv */
`timescale 1ns/100ps
`default_nettype none

module game_input_mapper
	import system1_pkg::*;
(
	input  wire              clk_sys,
	input  wire              rst_n,
	input  wire game_id_t    core_mod,
	input  wire player_ctl_t p1,
	input  wire player_ctl_t p2,
	input  wire sys_ctl_t    sys,
	input  wire [31:0]       status,
	output logic [7:0]       inp0,
	output logic [7:0]       inp1,
	output logic [7:0]       inp2,
	output logic [7:0]       dsw0,
	output logic [7:0]       dsw1
);

	logic known;    // core_mod names a game
	logic ud_en;    // 4-way stick
	logic fb_en;    // second fire button

	function automatic logic [7:0] pack_player(player_ctl_t p, logic ud, logic fb);
		return ~{p.left, p.right, p.up & ud, p.down & ud, 1'b0, p.fire_a, p.fire_b & fb, 1'b0};
	endfunction

	always_comb
	begin
		known = 1'b1;
		ud_en = 1'b0;
		fb_en = 1'b0;
		case (core_mod)
			GAME_FLICKY: ;
			GAME_PITFALL2: fb_en = 1'b1;
			GAME_STARJACKER, GAME_REGULUS:
			begin
				ud_en = 1'b1;
				fb_en = 1'b1;
			end
			GAME_UPNDOWN, GAME_MYHERO, GAME_NINJA, GAME_MRVIKING: ud_en = 1'b1;
			default: known = 1'b0;
		endcase
	end

	always_ff @(posedge clk_sys or negedge rst_n)
	begin
		if (!rst_n)
		begin
			inp0 <= 8'hFF;
			inp1 <= 8'hFF;
			inp2 <= 8'hFF;
			dsw0 <= 8'hFF;
			dsw1 <= 8'hFF;
		end
		else if (!known)
		begin
			inp0 <= 8'hFF;
			inp1 <= 8'hFF;
			inp2 <= 8'hFF;
			dsw0 <= 8'hFF;
			dsw1 <= 8'hFF;
		end
		else
		begin
			inp0 <= pack_player(p1, ud_en, fb_en);
			inp1 <= pack_player(p2, ud_en, fb_en);
			// service switch only on the later boards
			inp2 <= ~{2'b00, sys.start2, sys.start1, status[6] & ud_en, 2'b00, sys.coin};
			dsw0 <= 8'hFF;
			dsw1 <= {~status[12], ~status[11:10], ~status[9:8], 3'b000}; // diff, extend, lives
		end
	end

endmodule

`default_nettype wire

/* design/system1_loader_top.sv */
`timescale 1ns/100ps
`default_nettype none

module system1_loader_top
	import system1_pkg::*;
(
	input  wire              clk_sys,
	input  wire              rst_n,
	input  wire              ioctl_download,
	input  wire              ioctl_wr,
	input  wire dl_addr_t    ioctl_addr,
	input  wire [7:0]        ioctl_dout,
	input  wire [31:0]       status,
	input  wire [1:0]        buttons,
	input  wire game_id_t    core_mod,
	input  wire player_ctl_t p1,
	input  wire player_ctl_t p2,
	input  wire sys_ctl_t    sys,
	input  wire              mem_ack,
	output mem_cmd_t         mem_cmd,
	output logic             mem_req,
	output logic             dl_overflow,
	output logic             rom_loaded,
	output logic             core_reset,
	output logic             led,
	output logic [7:0]       inp0,
	output logic [7:0]       inp1,
	output logic [7:0]       inp2,
	output logic [7:0]       dsw0,
	output logic [7:0]       dsw1
);

	dl_byte_t dl_byte;
	logic dl_valid;
	mem_cmd_t cmd;
	logic cmd_valid;
	logic credit_return;

	assign led = ~ioctl_download;   // lit while idle

	dl_receiver dl_receiver_i (
		.clk_sys        (clk_sys),
		.rst_n          (rst_n),
		.ioctl_download (ioctl_download),
		.ioctl_wr       (ioctl_wr),
		.ioctl_addr     (ioctl_addr),
		.ioctl_dout     (ioctl_dout),
		.status_reset   (status[0]),
		.button_reset   (buttons[1]),
		.dl_byte        (dl_byte),
		.dl_valid       (dl_valid),
		.rom_loaded     (rom_loaded),
		.core_reset     (core_reset)
	);

	dl_addr_mapper dl_addr_mapper_i (
		.clk_sys        (clk_sys),
		.rst_n          (rst_n),
		.dl_byte        (dl_byte),
		.dl_valid       (dl_valid),
		.credit_return  (credit_return),
		.cmd            (cmd),
		.cmd_valid      (cmd_valid),
		.dl_overflow    (dl_overflow)
	);

	rom_write_queue rom_write_queue_i (
		.clk_sys        (clk_sys),
		.rst_n          (rst_n),
		.cmd            (cmd),
		.cmd_valid      (cmd_valid),
		.mem_ack        (mem_ack),
		.credit_return  (credit_return),
		.mem_cmd        (mem_cmd),
		.mem_req        (mem_req)
	);

	game_input_mapper game_input_mapper_i (
		.clk_sys        (clk_sys),
		.rst_n          (rst_n),
		.core_mod       (core_mod),
		.p1             (p1),
		.p2             (p2),
		.sys            (sys),
		.status         (status),
		.inp0           (inp0),
		.inp1           (inp1),
		.inp2           (inp2),
		.dsw0           (dsw0),
		.dsw1           (dsw1)
	);

endmodule

`default_nettype wire

/* bench/tb_sdram_model.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_sdram_model
	import system1_pkg::*;
(
	input  wire            clk_sys,
	input  wire            rst_n,
	input  wire mem_cmd_t  mem_cmd,
	input  wire            mem_req,
	input  wire            stall,
	output logic           mem_ack,
	output mem_cmd_t       log_cmd,
	output logic           log_valid
);

	logic [15:0] lfsr_state = 16'd53;
	logic        busy;
	logic [2:0]  delay;   // cycles left before the ack

	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		if (s[0])
			return (s >> 1) ^ 16'hB400;
		else
			return s >> 1;
	endfunction

	always @(posedge clk_sys or negedge rst_n)
	begin
		if (!rst_n)
		begin
			mem_ack   <= 1'b0;
			busy      <= 1'b0;
			delay     <= 3'd0;
			log_valid <= 1'b0;
		end
		else
		begin
			log_valid <= 1'b0;
			if (!busy && mem_req != mem_ack)
			begin
				for (int i = 0; i < 3; i++)
				begin
					delay[i] <= lfsr_state[0];
					lfsr_state = lfsr_next(lfsr_state);
				end
				busy <= 1'b1;
			end
			else if (busy && !stall)
			begin
				if (delay == 3'd0)
				begin
					mem_ack   <= mem_req;
					busy      <= 1'b0;
					log_cmd   <= mem_cmd; // write log entry
					log_valid <= 1'b1;
				end
				else
					delay <= delay - 3'd1;
			end
		end
	end

endmodule

`default_nettype wire

/* bench/tb_system1_loader.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_system1_loader
	import system1_pkg::*;
();

	localparam int BYTES_DRIVEN    = 26;
	localparam int WATCHDOG_CYCLES = BYTES_DRIVEN * 40 + 3000;
	localparam int DRAIN_LIMIT     = 200;

	logic clk_sys;
	logic rst_n;
	logic ioctl_download;
	logic ioctl_wr;
	dl_addr_t ioctl_addr;
	logic [7:0] ioctl_dout;
	logic [31:0] status;
	logic [1:0] buttons;
	game_id_t core_mod;
	player_ctl_t p1;
	player_ctl_t p2;
	sys_ctl_t sys;
	logic mem_ack;
	mem_cmd_t mem_cmd;
	logic mem_req;
	logic dl_overflow;
	logic rom_loaded;
	logic core_reset;
	logic led;
	logic [7:0] inp0;
	logic [7:0] inp1;
	logic [7:0] inp2;
	logic [7:0] dsw0;
	logic [7:0] dsw1;
	logic stall;
	mem_cmd_t log_cmd;
	logic log_valid;

	mem_cmd_t exp_q[$];   // writes still owed by the DUT
	mem_cmd_t want_cmd;
	logic [15:0] lfsr_state = 16'd53;
	int err_count = 0;
	int pass_count = 0;
	int fail_count = 0;

	system1_loader_top system1_loader_top_i (
		.clk_sys(clk_sys), .rst_n(rst_n),
		.ioctl_download(ioctl_download), .ioctl_wr(ioctl_wr),
		.ioctl_addr(ioctl_addr), .ioctl_dout(ioctl_dout),
		.status(status), .buttons(buttons), .core_mod(core_mod),
		.p1(p1), .p2(p2), .sys(sys), .mem_ack(mem_ack),
		.mem_cmd(mem_cmd), .mem_req(mem_req), .dl_overflow(dl_overflow),
		.rom_loaded(rom_loaded), .core_reset(core_reset), .led(led),
		.inp0(inp0), .inp1(inp1), .inp2(inp2), .dsw0(dsw0), .dsw1(dsw1)
	);

	tb_sdram_model sdram_model_i (
		.clk_sys(clk_sys), .rst_n(rst_n), .mem_cmd(mem_cmd), .mem_req(mem_req),
		.stall(stall), .mem_ack(mem_ack), .log_cmd(log_cmd), .log_valid(log_valid)
	);

	initial
	begin
		clk_sys = 1'b0;
		forever #10 clk_sys = ~clk_sys;
	end

	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		if (s[0])
			return (s >> 1) ^ 16'hB400;
		else
			return s >> 1;
	endfunction

	task automatic take_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++)
		begin
			v = {v[30:0], lfsr_state[0]};
			lfsr_state = lfsr_next(lfsr_state);
		end
	endtask

	// expected sdram write for one rom byte
	function automatic mem_cmd_t ref_cmd(input dl_addr_t a, input logic [7:0] d);
		mem_cmd_t c;
		dl_addr_t off;
		c.data = {d, d};
		if (a < TILE_BASE)
		begin
			c.port = 1'b0;
			c.addr = a[23:1];
			c.lane = a[0] ? 2'b10 : 2'b01;
		end
		else
		begin
			off = a - TILE_BASE;
			c.port = 1'b1;
			c.addr = {6'd0, off[17:16], off[13:0], off[15]};
			c.lane = off[14] ? 2'b10 : 2'b01;
		end
		return c;
	endfunction

	// {inp0, inp1, inp2, dsw0, dsw1}
	function automatic logic [39:0] expected_inputs(input game_id_t g, input player_ctl_t a,
		input player_ctl_t b, input sys_ctl_t s, input logic [31:0] st);
		logic ud;
		logic fb;
		logic [7:0] i0;
		logic [7:0] i1;
		logic [7:0] i2;
		logic [7:0] d1;
		if (g > 7)
			return {5{8'hFF}};
		ud = g >= 2;
		fb = g >= 1 && g <= 3;
		i0 = ~{a.left, a.right, a.up & ud, a.down & ud, 1'b0, a.fire_a, a.fire_b & fb, 1'b0};
		i1 = ~{b.left, b.right, b.up & ud, b.down & ud, 1'b0, b.fire_a, b.fire_b & fb, 1'b0};
		i2 = ~{2'b00, s.start2, s.start1, st[6] & ud, 2'b00, s.coin};
		d1 = {~st[12:8], 3'b000};
		return {i0, i1, i2, 8'hFF, d1};
	endfunction

	task automatic check_bit(input string name, input logic got, input logic want);
		if (got !== want)
		begin
			$display("MISMATCH %s: got %h expected %h", name, got, want);
			err_count++;
		end
	endtask

	task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] want);
		if (got !== want)
		begin
			$display("MISMATCH %s: got %h expected %h", name, got, want);
			err_count++;
		end
	endtask

	task automatic send_byte(input dl_addr_t a, input logic [7:0] d);
		@(posedge clk_sys);
		ioctl_addr <= a;
		ioctl_dout <= d;
		ioctl_wr   <= 1'b1;
		@(posedge clk_sys);
		ioctl_wr <= 1'b0;
		repeat (8) @(posedge clk_sys); // 10 cycle strobe spacing
	endtask

	task automatic expect_byte(input dl_addr_t a, input logic [7:0] d);
		exp_q.push_back(ref_cmd(a, d));
		send_byte(a, d);
	endtask

	task automatic drain_writes();
		int waited;
		waited = 0;
		while (exp_q.size() != 0 && waited < DRAIN_LIMIT)
		begin
			@(posedge clk_sys);
			waited++;
		end
		if (exp_q.size() != 0)
		begin
			$display("%0d expected memory writes never arrived", exp_q.size());
			err_count++;
			exp_q.delete();
		end
		repeat (20) @(posedge clk_sys); // room for stray writes
	endtask

	task automatic settle();
		repeat (2) @(posedge clk_sys);
		@(negedge clk_sys);
	endtask

	task automatic end_test(input int num, input string name, input int errs);
		if (err_count == errs)
		begin
			pass_count++;
			$display("test %0d %s: ok", num, name);
		end
		else
		begin
			fail_count++;
			$display("test %0d %s: FAILED with %0d errors", num, name, err_count - errs);
		end
	endtask

	always @(posedge clk_sys)
	begin
		if (rst_n && log_valid)
		begin
			if (exp_q.size() == 0)
			begin
				$display("unexpected memory write, port %0d word %h", log_cmd.port, log_cmd.addr);
				err_count++;
			end
			else
			begin
				want_cmd = exp_q.pop_front();
				if (log_cmd !== want_cmd)
				begin
					$display("MISMATCH mem_cmd: got %h expected %h", log_cmd, want_cmd);
					err_count++;
				end
			end
		end
	end

	initial
	begin
		repeat (WATCHDOG_CYCLES) @(posedge clk_sys);
		$display("watchdog expired before the tests finished");
		$display("Test failures found");
		$finish;
	end

	initial
	begin
		int errs;
		logic [31:0] rv;
		dl_addr_t a;
		player_ctl_t p1v;
		player_ctl_t p2v;
		sys_ctl_t sv;
		logic [31:0] stv;
		logic [39:0] e;

		rst_n = 1'b0;
		ioctl_download = 1'b0;
		ioctl_wr = 1'b0;
		ioctl_addr = '0;
		ioctl_dout = 8'h00;
		status = '0;
		buttons = 2'b00;
		core_mod = GAME_FLICKY;
		p1 = '0;
		p2 = '0;
		sys = '0;
		stall = 1'b0;
		repeat (3) @(posedge clk_sys);
		rst_n <= 1'b1;

		// loaded flag and core reset
		errs = err_count;
		@(negedge clk_sys);
		check_bit("core_reset", core_reset, 1'b1);
		check_bit("rom_loaded", rom_loaded, 1'b0);
		check_bit("led", led, 1'b1);
		check_bit("mem_req", mem_req, 1'b0);
		check_bit("dl_overflow", dl_overflow, 1'b0);
		@(posedge clk_sys);
		ioctl_download <= 1'b1;
		settle();
		check_bit("led", led, 1'b0);
		check_bit("core_reset", core_reset, 1'b1);
		@(posedge clk_sys);
		ioctl_download <= 1'b0;
		repeat (3) @(posedge clk_sys);
		@(negedge clk_sys);
		check_bit("rom_loaded", rom_loaded, 1'b1);
		check_bit("core_reset", core_reset, 1'b0);
		check_bit("led", led, 1'b1);
		@(posedge clk_sys);
		status[0] <= 1'b1;
		settle();
		check_bit("core_reset", core_reset, 1'b1);
		@(posedge clk_sys);
		status[0] <= 1'b0;
		settle();
		check_bit("core_reset", core_reset, 1'b0);
		@(posedge clk_sys);
		buttons[1] <= 1'b1;
		settle();
		check_bit("core_reset", core_reset, 1'b1);
		@(posedge clk_sys);
		buttons[1] <= 1'b0;
		ioctl_download <= 1'b1; // second download for the rom tests
		settle();
		check_bit("core_reset", core_reset, 1'b0);
		end_test(5, "loaded flag and core reset", errs);

		errs = err_count;
		for (int i = 0; i < 8; i++)
		begin
			take_bits(17, rv);
			a = {8'd0, rv[16:0]};
			take_bits(8, rv);
			expect_byte(a, rv[7:0]);
		end
		drain_writes();
		@(negedge clk_sys);
		check_bit("dl_overflow", dl_overflow, 1'b0);
		end_test(1, "main region", errs);

		errs = err_count;
		for (int k = 0; k < 8; k++)
		begin
			take_bits(14, rv);
			if (k[1:0] == 2'b11)
				a = TILE_BASE + {9'd0, k[1:0], 7'd0, rv[6:0]};  // keep below ROM_END
			else
				a = TILE_BASE + {9'd0, k[1:0], rv[13:0]};
			take_bits(8, rv);
			expect_byte(a, rv[7:0]);
		end
		drain_writes();
		end_test(2, "tile region", errs);

		errs = err_count;
		send_byte(ROM_END, 8'hA5);
		send_byte(ROM_END + 25'h1234, 8'h5A);
		send_byte(25'h1FFFFFF, 8'h3C);
		take_bits(12, rv);
		expect_byte(TILE_BASE + {13'd0, rv[11:0]}, 8'h96);
		drain_writes();
		end_test(3, "out of range", errs);

		errs = err_count;
		@(posedge clk_sys);
		stall <= 1'b1;
		for (int i = 0; i < 6; i++)
		begin
			take_bits(17, rv);
			a = {8'd0, rv[16:0]};
			take_bits(8, rv);
			if (i < QUEUE_DEPTH)
				expect_byte(a, rv[7:0]);
			else
				send_byte(a, rv[7:0]); // no credit left
		end
		@(negedge clk_sys);
		check_bit("dl_overflow", dl_overflow, 1'b1);
		if (mem_req === mem_ack)
		begin
			$display("no memory request outstanding while stalled");
			err_count++;
		end
		@(posedge clk_sys);
		stall <= 1'b0;
		drain_writes();
		@(negedge clk_sys);
		check_bit("dl_overflow", dl_overflow, 1'b1);
		end_test(4, "back-pressure", errs);

		errs = err_count;
		for (int g = 0; g <= 8; g++)
		begin
			take_bits(6, rv);
			p1v = rv[5:0];
			take_bits(6, rv);
			p2v = rv[5:0];
			take_bits(3, rv);
			sv = rv[2:0];
			take_bits(32, stv);
			@(posedge clk_sys);
			core_mod <= game_id_t'(g);
			p1 <= p1v;
			p2 <= p2v;
			sys <= sv;
			status <= stv;
			settle();
			e = expected_inputs(game_id_t'(g), p1v, p2v, sv, stv);
			check_byte("inp0", inp0, e[39:32]);
			check_byte("inp1", inp1, e[31:24]);
			check_byte("inp2", inp2, e[23:16]);
			check_byte("dsw0", dsw0, e[15:8]);
			check_byte("dsw1", dsw1, e[7:0]);
		end
		end_test(6, "game input mapping", errs);

		$display("%0d tests ok, %0d tests failed", pass_count, fail_count);
		if (fail_count == 0 && err_count == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

endmodule

`default_nettype wire

/* filelist.f */
design/system1_pkg.sv
design/dl_receiver.sv
design/dl_addr_mapper.sv
design/rom_write_queue.sv
design/game_input_mapper.sv
design/system1_loader_top.sv
bench/tb_sdram_model.sv
bench/tb_system1_loader.sv
